/* source/cache_pkg.sv */
// Line size is fixed at 32 bytes and addresses at 32 bits; set count and tag width belong to the modules.
`default_nettype none

package cache_pkg;

    // Byte offset width within one line.
    localparam int s_offset = 5;
    localparam int s_line_bytes = 2 ** s_offset;

    typedef logic [31:0] addr_t;
    typedef logic [8*s_line_bytes-1:0] line_t;
    typedef logic [s_line_bytes-1:0] byte_en_t;

    // CPU request, held stable until mem_resp.
    typedef struct packed {
        logic     read;
        logic     write;
        addr_t    address;
        line_t    wdata;
        byte_en_t byte_enable;
    } cpu_req_t;

    // Physical memory request, one of read or write at a time.
    typedef struct packed {
        logic  read;
        logic  write;
        addr_t address;
        line_t wdata;
    } pmem_req_t;

    // Datapath strobes driven by the controller.
    typedef struct packed {
        logic load_line;
        logic load_tag;
        logic use_cpu_data;
        logic set_dirty;
        logic clear_dirty;
        logic update_lru;
        logic writeback_addr;
    } ctrl_t;

    // Datapath status seen by the controller.
    typedef struct packed {
        logic hit;
        logic victim_dirty;
    } dp_status_t;

    typedef enum logic [1:0] {
        idle,
        check,
        writeback,
        fill
    } cache_state_e;

endpackage

`default_nettype wire

/* source/cache_data_array.sv */
// One way of line storage in flops; read is combinational, contents are undefined until filled.
`timescale 1ns/100ps
`default_nettype none

module cache_data_array #(
    parameter int s_index = 3
)
(
    input  logic                clk,
    input  cache_pkg::byte_en_t write_mask,
    input  logic [s_index-1:0]  index,
    input  cache_pkg::line_t    wdata,
    output cache_pkg::line_t    rdata
);

    localparam int num_sets = 2 ** s_index;

    cache_pkg::line_t lines [num_sets];

    // Each set byte lane is written independently.
    always_ff @(posedge clk)
    begin
        for (int b = 0; b < cache_pkg::s_line_bytes; b++)
        begin
            if (write_mask[b])
            begin
                lines[index][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end

    assign rdata = lines[index];

endmodule

`default_nettype wire

/* source/cache_meta_array.sv */
// Two-way tag, valid and dirty store plus one LRU bit per set; tags hold garbage until valid.
`timescale 1ns/100ps
`default_nettype none

module cache_meta_array #(
    parameter int s_index = 3
)
(
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic [s_index-1:0]                            index,
    input  logic [31-cache_pkg::s_offset-s_index:0]       tag_in,
    input  logic [1:0]                                    load_tag,
    input  logic [1:0]                                    dirty_load,
    input  logic                                          dirty_in,
    input  logic                                          lru_load,
    input  logic                                          lru_in,
    output logic [1:0][31-cache_pkg::s_offset-s_index:0]  tags,
    output logic [1:0]                                    valid,
    output logic [1:0]                                    dirty,
    output logic                                          lru
);

    localparam int num_sets = 2 ** s_index;
    localparam int s_tag = 32 - cache_pkg::s_offset - s_index;

    logic [1:0][s_tag-1:0] tag_mem [num_sets];
    logic [1:0]            valid_mem [num_sets];
    logic [1:0]            dirty_mem [num_sets];
    logic [num_sets-1:0]   lru_mem;

    // Control bits, cleared for every set on reset.
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            valid_mem <= '{default: '0};
            dirty_mem <= '{default: '0};
            lru_mem <= '0;
        end
        else
        begin
            for (int w = 0; w < 2; w++)
            begin
                // A new tag makes the way valid.
                if (load_tag[w])
                begin
                    valid_mem[index][w] <= 1'b1;
                end
                if (dirty_load[w])
                begin
                    dirty_mem[index][w] <= dirty_in;
                end
            end
            if (lru_load)
            begin
                lru_mem[index] <= lru_in;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        for (int w = 0; w < 2; w++)
        begin
            if (load_tag[w])
            begin
                tag_mem[index][w] <= tag_in;
            end
        end
    end

    assign tags = tag_mem[index];
    assign valid = valid_mem[index];
    assign dirty = dirty_mem[index];
    assign lru = lru_mem[index];

endmodule

`default_nettype wire

/* source/cache_datapath.sv */
// Combinational apart from the arrays; LRU bit names the victim way, cpu_req must be stable all request.
`timescale 1ns/100ps
`default_nettype none

module cache_datapath #(
    parameter int s_index = 3
)
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  cache_pkg::cpu_req_t     cpu_req,
    input  cache_pkg::ctrl_t        ctrl,
    input  cache_pkg::line_t        pmem_rdata,
    output cache_pkg::dp_status_t   status,
    output cache_pkg::line_t        mem_rdata,
    output cache_pkg::addr_t        pmem_address,
    output cache_pkg::line_t        pmem_wdata
);

    localparam int s_tag = 32 - cache_pkg::s_offset - s_index;

    logic [s_tag-1:0]      req_tag;
    logic [s_index-1:0]    req_index;
    logic [1:0][s_tag-1:0] tags;
    logic [1:0]            valid;
    logic [1:0]            dirty;
    logic                  lru;
    logic [1:0]            way_hit;
    logic                  hit;
    logic                  target_way;
    logic [1:0]            tag_load;
    logic [1:0]            dirty_load;
    cache_pkg::byte_en_t   line_mask;
    cache_pkg::line_t      line_wdata;
    cache_pkg::byte_en_t   way_mask [2];
    cache_pkg::line_t      way_rdata [2];
    cache_pkg::line_t      target_line;

    assign req_tag = cpu_req.address[31 -: s_tag];
    assign req_index = cpu_req.address[cache_pkg::s_offset +: s_index];

    assign way_hit[0] = valid[0] && (tags[0] == req_tag);
    assign way_hit[1] = valid[1] && (tags[1] == req_tag);
    assign hit = |way_hit;

    // Hitting way on a hit, else the LRU victim.
    assign target_way = hit ? way_hit[1] : lru;

    assign status.hit = hit;
    assign status.victim_dirty = dirty[target_way];

    assign tag_load = {ctrl.load_tag && target_way, ctrl.load_tag && !target_way};
    assign dirty_load = {2{ctrl.set_dirty || ctrl.clear_dirty}}
                        & {target_way, !target_way};

    // A fill writes the whole line, a CPU store only its enabled bytes.
    assign line_mask = ctrl.use_cpu_data ? cpu_req.byte_enable : '1;
    assign line_wdata = ctrl.use_cpu_data ? cpu_req.wdata : pmem_rdata;

    cache_meta_array #(
        .s_index (s_index)
    ) u_meta_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .index      (req_index),
        .tag_in     (req_tag),
        .load_tag   (tag_load),
        .dirty_load (dirty_load),
        .dirty_in   (ctrl.set_dirty),
        .lru_load   (ctrl.update_lru),
        .lru_in     (!target_way),
        .tags       (tags),
        .valid      (valid),
        .dirty      (dirty),
        .lru        (lru)
    );

    for (genvar w = 0; w < 2; w++)
    begin : g_way
        assign way_mask[w] = (ctrl.load_line && (target_way == 1'(w))) ? line_mask : '0;

        cache_data_array #(
            .s_index (s_index)
        ) u_data_array (
            .clk        (clk),
            .write_mask (way_mask[w]),
            .index      (req_index),
            .wdata      (line_wdata),
            .rdata      (way_rdata[w])
        );
    end

    assign target_line = way_rdata[target_way];
    assign mem_rdata = target_line;
    assign pmem_wdata = target_line;

    // Writeback goes to the victim's own line address.
    assign pmem_address = ctrl.writeback_addr
        ? {tags[target_way], req_index, {cache_pkg::s_offset{1'b0}}}
        : {cpu_req.address[31:cache_pkg::s_offset], {cache_pkg::s_offset{1'b0}}};

endmodule

`default_nettype wire

/* source/cache_control.sv */
// One request at a time; CPU read and write must not both be set, pmem_resp is a one-cycle pulse.
`timescale 1ns/100ps
`default_nettype none

module cache_control
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cpu_read,
    input  logic                  cpu_write,
    input  cache_pkg::dp_status_t status,
    input  logic                  pmem_resp,
    output cache_pkg::ctrl_t      ctrl,
    output logic                  pmem_read,
    output logic                  pmem_write,
    output logic                  mem_resp
);

    cache_pkg::cache_state_e state;
    cache_pkg::cache_state_e next_state;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= cache_pkg::idle;
        end
        else
        begin
            state <= next_state;
        end
    end

    always_comb
    begin
        next_state = state;
        ctrl = '0;
        pmem_read = 1'b0;
        pmem_write = 1'b0;
        mem_resp = 1'b0;

        unique case (state)
            cache_pkg::idle:
            begin
                if (cpu_read || cpu_write)
                begin
                    next_state = cache_pkg::check;
                end
            end

            cache_pkg::check:
            begin
                if (status.hit)
                begin
                    mem_resp = 1'b1;
                    ctrl.update_lru = 1'b1;
                    // Store hit merges into the line and marks it dirty.
                    if (cpu_write)
                    begin
                        ctrl.load_line = 1'b1;
                        ctrl.use_cpu_data = 1'b1;
                        ctrl.set_dirty = 1'b1;
                    end
                    next_state = cache_pkg::idle;
                end
                else if (status.victim_dirty)
                begin
                    next_state = cache_pkg::writeback;
                end
                else
                begin
                    next_state = cache_pkg::fill;
                end
            end

            cache_pkg::writeback:
            begin
                pmem_write = 1'b1;
                ctrl.writeback_addr = 1'b1;
                if (pmem_resp)
                begin
                    ctrl.clear_dirty = 1'b1;
                    next_state = cache_pkg::fill;
                end
            end

            cache_pkg::fill:
            begin
                pmem_read = 1'b1;
                if (pmem_resp)
                begin
                    ctrl.load_line = 1'b1;
                    ctrl.load_tag = 1'b1;
                    ctrl.clear_dirty = 1'b1;
                    // Back to check, which now hits.
                    next_state = cache_pkg::check;
                end
            end

            default:
            begin
                next_state = cache_pkg::idle;
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/cache_top.sv */
// Two-way write-back cache with 32-byte lines; requests are levels held until the response pulse.
`timescale 1ns/100ps
`default_nettype none

module cache_top #(
    parameter int s_index = 3
)
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  cache_pkg::cpu_req_t   cpu_req,
    output logic                  mem_resp,
    output cache_pkg::line_t      mem_rdata,
    output cache_pkg::pmem_req_t  pmem_req,
    input  logic                  pmem_resp,
    input  cache_pkg::line_t      pmem_rdata
);

    cache_pkg::ctrl_t      ctrl;
    cache_pkg::dp_status_t status;
    logic                  pmem_read;
    logic                  pmem_write;
    cache_pkg::addr_t      pmem_address;
    cache_pkg::line_t      pmem_wdata;

    cache_control u_cache_control (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_read   (cpu_req.read),
        .cpu_write  (cpu_req.write),
        .status     (status),
        .pmem_resp  (pmem_resp),
        .ctrl       (ctrl),
        .pmem_read  (pmem_read),
        .pmem_write (pmem_write),
        .mem_resp   (mem_resp)
    );

    cache_datapath #(
        .s_index (s_index)
    ) u_cache_datapath (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_req      (cpu_req),
        .ctrl         (ctrl),
        .pmem_rdata   (pmem_rdata),
        .status       (status),
        .mem_rdata    (mem_rdata),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata)
    );

    // Strobes come from control, address and data from the datapath.
    assign pmem_req = '{
        read:    pmem_read,
        write:   pmem_write,
        address: pmem_address,
        wdata:   pmem_wdata
    };

endmodule

`default_nettype wire

/* verif/pmem_model.sv */
// Sparse line memory; unwritten lines read as a seeded address pattern, replies come 1 to 4 cycles late.
`timescale 1ns/100ps
`default_nettype none

module pmem_model #(
    parameter int seed = 32'h1cc109cf
)
(
    input  logic                 clk,
    input  cache_pkg::pmem_req_t pmem_req,
    output logic                 pmem_resp,
    output cache_pkg::line_t     pmem_rdata,
    output cache_pkg::addr_t     last_write_addr
);

    cache_pkg::line_t mem [cache_pkg::addr_t];
    cache_pkg::addr_t write_log [$];
    integer           delay_seed;
    int               wait_left;
    logic             busy;

    // Each 32-bit word mixes its own byte address with the seed.
    function automatic cache_pkg::line_t initial_line(input cache_pkg::addr_t a);
        cache_pkg::line_t l;
        for (int w = 0; w < 8; w++)
        begin
            l[32*w +: 32] = ((a + 32'(4 * w)) * 32'h9e3779b1) ^ seed;
        end
        return l;
    endfunction

    initial
    begin
        delay_seed = seed;
        pmem_resp = 1'b0;
        pmem_rdata = '0;
        last_write_addr = '0;
        busy = 1'b0;
        wait_left = 0;
        forever
        begin
            @(posedge clk);
            #1;
            pmem_resp = 1'b0;
            if (busy)
            begin
                wait_left = wait_left - 1;
                if (wait_left == 0)
                begin
                    busy = 1'b0;
                    pmem_resp = 1'b1;
                    if (pmem_req.write)
                    begin
                        mem[pmem_req.address] = pmem_req.wdata;
                        write_log.push_back(pmem_req.address);
                        last_write_addr = write_log[$];
                    end
                    else if (mem.exists(pmem_req.address))
                    begin
                        pmem_rdata = mem[pmem_req.address];
                    end
                    else
                    begin
                        pmem_rdata = initial_line(pmem_req.address);
                    end
                end
            end
            else if (pmem_req.read || pmem_req.write)
            begin
                busy = 1'b1;
                wait_left = 1 + int'({$random(delay_seed)} % 4);
            end
        end
    end

endmodule

`default_nettype wire

/* verif/cache_tb.sv */
// Assumes s_index 3 and addresses above 32'h8000_0000 using tag bits 10:8 only (64 tracked lines).
`timescale 1ns/100ps
`default_nettype none

module cache_tb;

    localparam int s_index = 3;
    localparam int tb_seed = 32'h1cc109cf;
    localparam int num_requests = 215;
    localparam int timeout_cycles = num_requests * 20;
    localparam cache_pkg::addr_t base_addr = 32'h8000_0000;

    logic                 clk = 1'b0;
    logic                 rst_n;
    cache_pkg::cpu_req_t  cpu_req;
    logic                 mem_resp;
    cache_pkg::line_t     mem_rdata;
    cache_pkg::pmem_req_t pmem_req;
    logic                 pmem_resp;
    cache_pkg::line_t     pmem_rdata;
    cache_pkg::addr_t     last_write_addr;

    integer           seed = tb_seed;
    string            test_name = "reset";
    cache_pkg::line_t shadow [64];
    cache_pkg::line_t read_expected;
    cache_pkg::line_t wb_expected;
    cache_pkg::addr_t aligned_addr;
    cache_pkg::addr_t expected_wb_addr = '0;
    int               cycle_count = 0;
    int               req_age = 0;
    logic             fill_seen = 1'b0;
    logic             resp_mid = 1'b0;
    logic             fill_mid = 1'b0;
    logic             quiet_phase = 1'b1;
    logic             expect_hit = 1'b0;
    logic             expect_miss = 1'b0;
    logic             expect_wb = 1'b0;
    logic             allow_pmem_write = 1'b0;

    always #50 clk = ~clk;

    cache_top #(
        .s_index (s_index)
    ) u_cache_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_req    (cpu_req),
        .mem_resp   (mem_resp),
        .mem_rdata  (mem_rdata),
        .pmem_req   (pmem_req),
        .pmem_resp  (pmem_resp),
        .pmem_rdata (pmem_rdata)
    );

    pmem_model #(
        .seed (tb_seed)
    ) u_pmem_model (
        .clk             (clk),
        .pmem_req        (pmem_req),
        .pmem_resp       (pmem_resp),
        .pmem_rdata      (pmem_rdata),
        .last_write_addr (last_write_addr)
    );

    // Memory image before any write, word by word from address and seed.
    function automatic cache_pkg::line_t initial_line(input cache_pkg::addr_t a);
        cache_pkg::line_t l;
        for (int w = 0; w < 8; w++)
        begin
            l[32*w +: 32] = ((a + 32'(4 * w)) * 32'h9e3779b1) ^ tb_seed;
        end
        return l;
    endfunction

    function automatic cache_pkg::addr_t line_addr(input int tag, input int index);
        return base_addr | cache_pkg::addr_t'(((tag % 8) * 8 + (index % 8)) * 32);
    endfunction

    task automatic stop_failed();
        $display("TESTS FAILED");
        $fatal(1, "Stopped at the first failing check.");
    endtask

    task automatic report_mismatch(input string check, input logic [255:0] expected,
                                   input logic [255:0] actual);
        $display("** Error: %s, %s: expected %h, actual %h", test_name, check, expected, actual);
        stop_failed();
    endtask

    task automatic report_problem(input string what);
        $display("Error in %s: %s", test_name, what);
        stop_failed();
    endtask

    // Handshake levels of the current cycle, seen before the next edge.
    always @(negedge clk)
    begin
        resp_mid <= mem_resp;
        fill_mid <= pmem_req.read && pmem_resp;
    end

    // Shadow memory and per-request bookkeeping.
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles)
        begin
            report_problem("timeout, the run did not finish within the cycle limit");
        end
        else if (!rst_n)
        begin
            for (int s = 0; s < 64; s++)
            begin
                shadow[s] <= initial_line(base_addr | cache_pkg::addr_t'(s * 32));
            end
            fill_seen <= 1'b0;
            req_age <= 0;
        end
        else if (resp_mid)
        begin
            if (cpu_req.write)
            begin
                for (int b = 0; b < 32; b++)
                begin
                    if (cpu_req.byte_enable[b])
                    begin
                        shadow[cpu_req.address[10:5]][8*b +: 8] <= cpu_req.wdata[8*b +: 8];
                    end
                end
            end
            fill_seen <= 1'b0;
            req_age <= 0;
        end
        else
        begin
            if (fill_mid)
            begin
                fill_seen <= 1'b1;
            end
            if (cpu_req.read || cpu_req.write)
            begin
                req_age <= req_age + 1;
            end
        end
    end

    always_comb
    begin
        read_expected = shadow[cpu_req.address[10:5]];
        wb_expected = shadow[pmem_req.address[10:5]];
        aligned_addr = {cpu_req.address[31:cache_pkg::s_offset], 5'b0};
    end

    quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        quiet_phase |-> !mem_resp && !pmem_req.read && !pmem_req.write)
        else report_problem("the cache became active with no request applied");

    read_data: assert property (@(posedge clk) disable iff (!rst_n)
        mem_resp && cpu_req.read |-> mem_rdata == read_expected)
        else report_mismatch("read data", $sampled(read_expected), $sampled(mem_rdata));

    fill_address: assert property (@(posedge clk) disable iff (!rst_n)
        pmem_req.read |-> pmem_req.address == aligned_addr)
        else report_mismatch("fill address", 256'($sampled(aligned_addr)),
                             256'($sampled(pmem_req.address)));

    hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
        expect_hit && mem_resp |-> req_age == 1)
        else report_mismatch("hit latency", 256'(1), 256'($sampled(req_age)));

    hit_no_pmem: assert property (@(posedge clk) disable iff (!rst_n)
        expect_hit |-> !pmem_req.read && !pmem_req.write)
        else report_problem("a hit accessed physical memory");

    miss_fill: assert property (@(posedge clk) disable iff (!rst_n)
        expect_miss && mem_resp |-> fill_seen)
        else report_problem("a miss completed without a memory read of its line");

    no_writeback: assert property (@(posedge clk) disable iff (!rst_n)
        !allow_pmem_write |-> !pmem_req.write)
        else report_problem("a memory write happened while none was due");

    victim_address: assert property (@(posedge clk) disable iff (!rst_n)
        expect_wb && mem_resp |-> last_write_addr == expected_wb_addr)
        else report_mismatch("writeback address", 256'($sampled(expected_wb_addr)),
                             256'($sampled(last_write_addr)));

    writeback_data: assert property (@(posedge clk) disable iff (!rst_n)
        pmem_req.write |-> pmem_req.wdata == wb_expected)
        else report_mismatch("writeback data", $sampled(wb_expected), $sampled(pmem_req.wdata));

    // Holds one request until mem_resp, then drops it after the edge.
    task automatic issue(input string name, input logic is_write, input cache_pkg::addr_t a,
                         input logic hit, input logic miss, input logic wb);
        cache_pkg::line_t d;
        logic             done;
        for (int w = 0; w < 8; w++)
        begin
            d[32*w +: 32] = $random(seed);
        end
        test_name = name;
        expect_hit = hit;
        expect_miss = miss;
        expect_wb = wb;
        cpu_req.address = a;
        cpu_req.wdata = d;
        cpu_req.byte_enable = $random(seed);
        cpu_req.write = is_write;
        cpu_req.read = !is_write;
        done = 1'b0;
        while (!done)
        begin
            @(negedge clk);
            done = mem_resp;
        end
        @(posedge clk);
        #1;
        cpu_req.read = 1'b0;
        cpu_req.write = 1'b0;
    endtask

    task automatic random_mix(input int count);
        int r;
        for (int i = 0; i < count; i++)
        begin
            r = $random(seed);
            issue("random_mix", r[9], line_addr(int'(r[3:2]), int'(r[1:0])) | 32'(r[8:4]),
                  1'b0, 1'b0, 1'b0);
        end
    endtask

    initial
    begin
        rst_n = 1'b0;
        cpu_req = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        quiet_phase = 1'b0;
        issue("first_read", 1'b0, line_addr(0, 1) | 32'h0c, 1'b0, 1'b1, 1'b0);
        issue("repeat_hit", 1'b0, line_addr(0, 1), 1'b1, 1'b0, 1'b0);
        issue("repeat_hit", 1'b0, line_addr(0, 1) | 32'h1f, 1'b1, 1'b0, 1'b0);
        issue("masked_write", 1'b1, line_addr(0, 1) | 32'h04, 1'b1, 1'b0, 1'b0);
        issue("masked_write", 1'b0, line_addr(0, 1), 1'b1, 1'b0, 1'b0);
        // Set 3 stays clean, so evicting B writes nothing.
        issue("clean_evict", 1'b0, line_addr(1, 3), 1'b0, 1'b1, 1'b0);
        issue("clean_evict", 1'b0, line_addr(2, 3), 1'b0, 1'b1, 1'b0);
        issue("clean_evict", 1'b0, line_addr(1, 3), 1'b1, 1'b0, 1'b0);
        issue("clean_evict", 1'b0, line_addr(3, 3), 1'b0, 1'b1, 1'b0);
        issue("clean_evict", 1'b0, line_addr(1, 3), 1'b1, 1'b0, 1'b0);
        // Both lines of set 4 end up dirty with B least recently used.
        allow_pmem_write = 1'b1;
        expected_wb_addr = line_addr(2, 4);
        issue("dirty_evict", 1'b1, line_addr(1, 4), 1'b0, 1'b1, 1'b0);
        issue("dirty_evict", 1'b1, line_addr(2, 4), 1'b0, 1'b1, 1'b0);
        issue("dirty_evict", 1'b0, line_addr(1, 4), 1'b1, 1'b0, 1'b0);
        issue("dirty_evict", 1'b0, line_addr(3, 4), 1'b0, 1'b1, 1'b1);
        issue("dirty_evict", 1'b0, line_addr(1, 4), 1'b1, 1'b0, 1'b0);
        random_mix(200);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* cache_top.f */
source/cache_pkg.sv
source/cache_data_array.sv
source/cache_meta_array.sv
source/cache_datapath.sv
source/cache_control.sv
source/cache_top.sv
verif/pmem_model.sv
verif/cache_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= cache_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= TESTS PASSED

SOURCES := $(wildcard source/*.sv verif/*.sv)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes.
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the pass line appears in the output.
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(OBJ_DIR)
